// ==== ooo_pkg.sv ====
package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_TAG_W  = 3;
    localparam int MUL_STAGES = 3;

    // major opcode field values
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct7 values of the R-type group
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    // funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_MUL,
        OP_BEQ,
        OP_BNE,
        OP_ILLEGAL
    } opcode_e;

    // decoded instruction leaving decode
    typedef struct packed {
        logic                 valid;
        opcode_e              opcode;
        logic [ROB_TAG_W-1:0] tag;
        logic [4:0]           rd;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
        logic [XLEN-1:0]      target;
    } issue_t;

    // finished instruction, alu or multiplier
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      result;
        logic                 taken;
    } complete_t;

    // in-order retirement
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } commit_t;

endpackage

// ==== insn_decode.sv ====
`timescale 1ns/1ps

module insn_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           insn_valid,
    input  logic [ooo_pkg::XLEN-1:0]       insn,
    input  logic [ooo_pkg::XLEN-1:0]       pc,
    input  logic [31:0]                    busy,
    input  logic [ooo_pkg::XLEN-1:0]       rs1_data,
    input  logic [ooo_pkg::XLEN-1:0]       rs2_data,
    output logic [4:0]                     rs1,
    output logic [4:0]                     rs2,
    input  logic                           rob_full,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]  rob_tail,
    input  logic                           flush,
    output logic                           stall,
    output ooo_pkg::issue_t                issue
);
    import ooo_pkg::*;

    opcode_e         op;
    logic            uses_rs1;
    logic            uses_rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic            hazard;

    assign rs1   = insn[19:15];
    assign rs2   = insn[24:20];
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

    always_comb begin
        op = OP_ILLEGAL;
        case (insn[6:0])
            OPC_OP: begin
                if (insn[31:25] == F7_BASE) begin
                    case (insn[14:12])
                        F3_ADD:  op = OP_ADD;
                        F3_AND:  op = OP_AND;
                        F3_OR:   op = OP_OR;
                        F3_XOR:  op = OP_XOR;
                        default: op = OP_ILLEGAL;
                    endcase
                end else if (insn[31:25] == F7_SUB && insn[14:12] == F3_ADD) begin
                    op = OP_SUB;
                end else if (insn[31:25] == F7_MUL && insn[14:12] == F3_ADD) begin
                    op = OP_MUL;
                end
            end
            OPC_OP_IMM: if (insn[14:12] == F3_ADD) op = OP_ADDI;
            OPC_BRANCH: begin
                if (insn[14:12] == F3_BEQ) op = OP_BEQ;
                else if (insn[14:12] == F3_BNE) op = OP_BNE;
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    // illegal words retire as no-ops with no register traffic
    assign uses_rs1 = (op != OP_ILLEGAL);
    assign uses_rs2 = (op != OP_ILLEGAL) && (op != OP_ADDI);
    assign rd = (op == OP_ILLEGAL || op == OP_BEQ || op == OP_BNE) ? 5'd0 : insn[11:7];

    assign hazard = insn_valid &&
                    ((uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) || busy[rd]);
    assign stall  = rob_full || flush || hazard;

    always_comb begin
        issue.valid  = insn_valid && !stall;
        issue.opcode = op;
        issue.tag    = rob_tail;
        issue.rd     = rd;
        issue.a      = rs1_data;
        issue.b      = (op == OP_ADDI) ? imm_i : rs2_data;
        issue.target = pc + imm_b;
    end

    a_no_issue_when_full: assert property (
        @(posedge clk) disable iff (rst) !(issue.valid && rob_full));

endmodule

// ==== int_execute.sv ====
`timescale 1ns/1ps

module int_execute (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  ooo_pkg::issue_t    issue,
    output ooo_pkg::complete_t alu_done,
    output ooo_pkg::complete_t mul_done
);
    import ooo_pkg::*;

    complete_t alu_q;
    complete_t mul_q [MUL_STAGES];
    logic      alu_sel;
    logic      mul_sel;

    assign mul_sel = issue.valid && (issue.opcode == OP_MUL);
    assign alu_sel = issue.valid && (issue.opcode != OP_MUL);

    // single alu stage, branches resolve here too
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_q.valid <= 1'b0;
        end else begin
            alu_q.valid  <= alu_sel;
            alu_q.tag    <= issue.tag;
            alu_q.taken  <= 1'b0;
            alu_q.result <= '0;
            case (issue.opcode)
                OP_ADD, OP_ADDI: alu_q.result <= issue.a + issue.b;
                OP_SUB:          alu_q.result <= issue.a - issue.b;
                OP_AND:          alu_q.result <= issue.a & issue.b;
                OP_OR:           alu_q.result <= issue.a | issue.b;
                OP_XOR:          alu_q.result <= issue.a ^ issue.b;
                OP_BEQ:          alu_q.taken  <= (issue.a == issue.b);
                OP_BNE:          alu_q.taken  <= (issue.a != issue.b);
                default:         alu_q.result <= '0;
            endcase
        end
    end

    // product formed in stage 0, then carried along
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int s = 0; s < MUL_STAGES; s++) begin
                mul_q[s].valid <= 1'b0;
            end
        end else begin
            mul_q[0].valid  <= mul_sel;
            mul_q[0].tag    <= issue.tag;
            mul_q[0].result <= issue.a * issue.b;
            mul_q[0].taken  <= 1'b0;
            for (int s = 1; s < MUL_STAGES; s++) begin
                mul_q[s] <= mul_q[s-1];
            end
        end
    end

    assign alu_done = alu_q;
    assign mul_done = mul_q[MUL_STAGES-1];

    // one ROB entry can only be in one unit
    a_distinct_tags: assert property (@(posedge clk) disable iff (rst)
        !(alu_done.valid && mul_done.valid && alu_done.tag == mul_done.tag));

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  ooo_pkg::issue_t               issue,
    input  ooo_pkg::complete_t            alu_done,
    input  ooo_pkg::complete_t            mul_done,
    output logic                          full,
    output logic [ooo_pkg::ROB_TAG_W-1:0] tail,
    output ooo_pkg::commit_t              commit,
    output logic                          flush,
    output logic [ooo_pkg::XLEN-1:0]      redirect_pc
);
    import ooo_pkg::*;

    // per-entry state
    logic [ROB_DEPTH-1:0] occupied;
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_DEPTH-1:0] is_branch;
    logic [ROB_DEPTH-1:0] taken;
    logic [4:0]           rd_q     [ROB_DEPTH];
    logic [XLEN-1:0]      data_q   [ROB_DEPTH];
    logic [XLEN-1:0]      target_q [ROB_DEPTH];

    logic [ROB_TAG_W-1:0] head;
    logic [ROB_TAG_W-1:0] tail_q;
    logic [ROB_TAG_W:0]   count;
    logic                 alloc;
    logic                 retire;

    logic                 commit_valid;
    logic [4:0]           commit_rd;
    logic [XLEN-1:0]      commit_data;

    assign alloc  = issue.valid;
    // nothing retires while the flush is in flight
    assign retire = occupied[head] && done[head] && !flush;
    assign full   = (count == (ROB_TAG_W+1)'(ROB_DEPTH));
    assign tail   = tail_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupied <= '0;
            done     <= '0;
            head     <= '0;
            tail_q   <= '0;
            count    <= '0;
        end else begin
            if (alloc) begin
                occupied[tail_q] <= 1'b1;
                done[tail_q]     <= 1'b0;
                tail_q           <= tail_q + 1'b1;
            end
            if (alu_done.valid) begin
                done[alu_done.tag] <= 1'b1;
            end
            if (mul_done.valid) begin
                done[mul_done.tag] <= 1'b1;
            end
            if (retire) begin
                occupied[head] <= 1'b0;
                done[head]     <= 1'b0;
                head           <= head + 1'b1;
            end
            count <= count + (ROB_TAG_W+1)'(alloc) - (ROB_TAG_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= retire;
            // predicted not-taken, so taken means mispredict
            flush        <= retire && is_branch[head] && taken[head];
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_q]      <= issue.rd;
            target_q[tail_q]  <= issue.target;
            is_branch[tail_q] <= (issue.opcode == OP_BEQ) || (issue.opcode == OP_BNE);
        end
        if (alu_done.valid) begin
            data_q[alu_done.tag] <= alu_done.result;
            taken[alu_done.tag]  <= alu_done.taken;
        end
        if (mul_done.valid) begin
            data_q[mul_done.tag] <= mul_done.result;
            taken[mul_done.tag]  <= mul_done.taken;
        end
        commit_rd   <= rd_q[head];
        commit_data <= data_q[head];
        redirect_pc <= target_q[head];
    end

    assign commit = '{valid: commit_valid, rd: commit_rd, data: commit_data};

    a_alu_hits_live_entry: assert property (@(posedge clk) disable iff (rst)
        alu_done.valid && !flush |-> occupied[alu_done.tag]);

    a_mul_hits_live_entry: assert property (@(posedge clk) disable iff (rst)
        mul_done.valid && !flush |-> occupied[mul_done.tag]);

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (ROB_TAG_W+1)'(ROB_DEPTH));

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    output logic [ooo_pkg::XLEN-1:0] rs1_data,
    output logic [ooo_pkg::XLEN-1:0] rs2_data,
    input  ooo_pkg::issue_t          issue,
    input  ooo_pkg::commit_t         commit,
    output logic [31:0]              busy
);
    import ooo_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (commit.valid && commit.rd != 5'd0) begin
            regs[commit.rd] <= commit.data;
        end
    end

    // scoreboard, cleared on commit, set on issue
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (commit.valid) begin
                busy[commit.rd] <= 1'b0;
            end
            if (issue.valid && issue.rd != 5'd0) begin
                busy[issue.rd] <= 1'b1;
            end
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    a_x0_never_busy: assert property (@(posedge clk) disable iff (rst) !busy[0]);

    // a register write only retires a pending producer
    a_commit_was_pending: assert property (@(posedge clk) disable iff (rst)
        commit.valid && commit.rd != 5'd0 |-> busy[commit.rd]);

endmodule

// ==== ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     insn_valid,
    input  logic [ooo_pkg::XLEN-1:0] insn,
    input  logic [ooo_pkg::XLEN-1:0] pc,
    output logic                     stall,
    output ooo_pkg::commit_t         commit,
    output logic                     flush,
    output logic [ooo_pkg::XLEN-1:0] redirect_pc
);
    import ooo_pkg::*;

    issue_t               issue;
    complete_t            alu_done;
    complete_t            mul_done;
    logic [31:0]          busy;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic                 rob_full;
    logic [ROB_TAG_W-1:0] rob_tail;

    insn_decode i_insn_decode (
        .clk(clk), .rst(rst),
        .insn_valid(insn_valid), .insn(insn), .pc(pc),
        .busy(busy), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1(rs1), .rs2(rs2),
        .rob_full(rob_full), .rob_tail(rob_tail), .flush(flush),
        .stall(stall), .issue(issue)
    );

    int_execute i_int_execute (
        .clk(clk), .rst(rst), .flush(flush),
        .issue(issue), .alu_done(alu_done), .mul_done(mul_done)
    );

    reorder_buffer i_reorder_buffer (
        .clk(clk), .rst(rst),
        .issue(issue), .alu_done(alu_done), .mul_done(mul_done),
        .full(rob_full), .tail(rob_tail),
        .commit(commit), .flush(flush), .redirect_pc(redirect_pc)
    );

    reg_file i_reg_file (
        .clk(clk), .rst(rst), .flush(flush),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .issue(issue), .commit(commit), .busy(busy)
    );

endmodule

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int PROG_LEN     = 48;
    localparam int RESET_CYCLES = 3;
    localparam int WATCH_CYCLES = RESET_CYCLES + PROG_LEN * (MUL_STAGES + ROB_DEPTH + 4);

    // architectural effect of one instruction
    typedef struct packed {
        logic            branch;
        logic            taken;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] next_pc;
    } step_t;

    logic            clk;
    logic            rst        = 1'b1;
    logic            insn_valid = 1'b0;
    logic [XLEN-1:0] insn       = '0;
    logic [XLEN-1:0] pc         = '0;
    logic            stall;
    commit_t         commit;
    logic            flush;
    logic [XLEN-1:0] redirect_pc;

    logic [XLEN-1:0] prog [PROG_LEN];
    logic [15:0]     lfsr;
    logic [XLEN-1:0] iss_regs [32];
    logic [XLEN-1:0] iss_pc;
    int              n_commits;
    logic            stall_seen = 1'b0;
    logic [31:0]     pending;
    int              in_flight;

    ooo_core i_ooo_core (
        .clk(clk), .rst(rst),
        .insn_valid(insn_valid), .insn(insn), .pc(pc),
        .stall(stall), .commit(commit), .flush(flush), .redirect_pc(redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int nbits, output int val);
        val = 0;
        for (int k = 0; k < nbits; k++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rd,
                                             input logic [4:0] rs1);
        return {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // random program over x1..x7, branches only jump forward inside it
    task automatic build_program();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int imm;
        int span;
        lfsr = 16'd36;
        for (int i = 0; i < PROG_LEN; i++) begin
            draw(4, kind);
            draw(3, rd);
            draw(3, rs1);
            draw(3, rs2);
            draw(5, imm);
            draw(2, span);
            rd   = 1 + rd % 7;
            rs1  = 1 + rs1 % 7;
            rs2  = 1 + rs2 % 7;
            imm  = imm - 16;
            span = (span + 1 > PROG_LEN - 1 - i) ? PROG_LEN - 1 - i : span + 1;
            if (span == 0 && (kind == 7 || kind == 8 || kind >= 14)) begin
                kind = 5;
            end
            case (kind)
                0, 13:     prog[i] = enc_r(F7_BASE, F3_ADD, rd, rs1, rs2);
                1:         prog[i] = enc_r(F7_SUB, F3_ADD, rd, rs1, rs2);
                2:         prog[i] = enc_r(F7_BASE, F3_AND, rd, rs1, rs2);
                3:         prog[i] = enc_r(F7_BASE, F3_OR, rd, rs1, rs2);
                4:         prog[i] = enc_r(F7_BASE, F3_XOR, rd, rs1, rs2);
                5, 9, 10:  prog[i] = enc_addi(imm, rd, rs1);
                6, 11, 12: prog[i] = enc_r(F7_MUL, F3_ADD, rd, rs1, rs2);
                7, 14:     prog[i] = enc_b(F3_BEQ, rs1, rs2, 13'(span * 4));
                default:   prog[i] = enc_b(F3_BNE, rs1, rs2, 13'(span * 4));
            endcase
        end
    endtask

    function automatic logic [31:0] word_at(input logic [XLEN-1:0] addr);
        return (addr < PROG_LEN * 4) ? prog[addr[31:2]] : '0;
    endfunction

    // reference ISS, reads the model register state
    function automatic step_t iss_step(input logic [31:0] w, input logic [XLEN-1:0] at);
        step_t           s;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        a     = iss_regs[w[19:15]];
        b     = iss_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        s     = '0;
        case (w[6:0])
            OPC_OP: begin
                s.rd = w[11:7];
                case ({w[31:25], w[14:12]})
                    {F7_BASE, F3_ADD}: s.data = a + b;
                    {F7_SUB, F3_ADD}:  s.data = a - b;
                    {F7_MUL, F3_ADD}:  s.data = a * b;
                    {F7_BASE, F3_AND}: s.data = a & b;
                    {F7_BASE, F3_OR}:  s.data = a | b;
                    {F7_BASE, F3_XOR}: s.data = a ^ b;
                    default:           s.rd = 5'd0;
                endcase
            end
            OPC_OP_IMM: begin
                if (w[14:12] == F3_ADD) begin
                    s.rd   = w[11:7];
                    s.data = a + imm_i;
                end
            end
            OPC_BRANCH: begin
                s.branch = (w[14:12] == F3_BEQ) || (w[14:12] == F3_BNE);
                s.taken  = (w[14:12] == F3_BEQ) ? (a == b) :
                           (w[14:12] == F3_BNE) ? (a != b) : 1'b0;
            end
            default: s.rd = 5'd0;
        endcase
        s.next_pc = s.taken ? at + imm_b : at + 4;
        return s;
    endfunction

    // true when the word reads or writes a register with a write still pending
    function automatic logic has_hazard(input logic [31:0] w, input logic [31:0] pend);
        logic [4:0] rd;
        logic       reads_rs2;
        rd        = (w[6:0] == OPC_BRANCH) ? 5'd0 : w[11:7];
        reads_rs2 = (w[6:0] != OPC_OP_IMM);
        return pend[w[19:15]] || (reads_rs2 && pend[w[24:20]]) || pend[rd];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    initial begin
        for (int r = 0; r < 32; r++) begin
            iss_regs[r] = '0;
        end
        iss_pc    = '0;
        n_commits = 0;
        pending   = '0;
        in_flight = 0;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    // predicted not-taken fetch, holds on stall, follows redirects
    always @(posedge clk) begin : fetch_driver
        logic [XLEN-1:0] addr;
        if (!rst) begin
            if (flush) begin
                addr = redirect_pc;
            end else if (insn_valid && !stall) begin
                addr = pc + 4;
            end else begin
                addr = pc;
            end
            if (insn_valid && stall && !flush) begin
                stall_seen <= 1'b1;
            end
            pc         <= addr;
            insn_valid <= (addr < PROG_LEN * 4);
            insn       <= word_at(addr);
        end
    end

    // every commit must be the next step on the ISS path
    always @(posedge clk) begin : commit_checker
        step_t want;
        if (!rst) begin
            if (commit.valid) begin
                want = iss_step(word_at(iss_pc), iss_pc);
                check_value("commit rd", commit.rd, want.rd);
                if (!want.branch) begin
                    check_value("commit data", commit.data, want.data);
                end
                check_value("flush", flush, want.taken);
                if (want.taken) begin
                    check_value("redirect_pc", redirect_pc, want.next_pc);
                end
                if (want.rd != 5'd0) begin
                    iss_regs[want.rd] = want.data;
                end
                iss_pc    = want.next_pc;
                n_commits = n_commits + 1;
                if (iss_pc >= PROG_LEN * 4) begin
                    check_value("stall observed", stall_seen, 32'd1);
                    $display("Simulation completed successfully");
                    $finish;
                end
            end else begin
                check_value("flush without commit", flush, 32'd0);
            end
        end
    end

    // stall follows the scoreboard, ROB occupancy and flush
    always @(posedge clk) begin : stall_checker
        logic want_stall;
        if (!rst) begin
            // a visible commit already left the ROB on the previous edge
            want_stall = flush || (in_flight - int'(commit.valid) == ROB_DEPTH) ||
                         (insn_valid && has_hazard(insn, pending));
            check_value("stall", stall, want_stall);
            if (flush) begin
                pending   = '0;
                in_flight = 0;
            end else begin
                if (commit.valid) begin
                    pending[commit.rd] = 1'b0;
                    in_flight          = in_flight - 1;
                end
                if (insn_valid && !stall) begin
                    if (insn[6:0] != OPC_BRANCH && insn[11:7] != 5'd0) begin
                        pending[insn[11:7]] = 1'b1;
                    end
                    in_flight = in_flight + 1;
                end
            end
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("commits stopped after %0d instructions, program did not finish", n_commits);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// ==== vlog.f ====
ooo_pkg.sv
insn_decode.sv
int_execute.sv
reorder_buffer.sv
reg_file.sv
ooo_core.sv
tb_ooo_core.sv
